// File: verilog.f
+incdir+hw
+incdir+tb
hw/intdiv_pkg.sv
hw/intdiv_step.sv
hw/intdiv_ctrl.sv
hw/intdiv_dpath.sv
hw/intdiv.sv
tb/intdiv_tb.sv

// File: tb/intdiv_tb_tasks.svh
/*
 * Divider testbench tasks
 * Request and response driving, plus the value compare
 */

`ifndef INTDIV_TB_TASKS_SVH
`define INTDIV_TB_TASKS_SVH

// Compare one value, report and count a mismatch
task automatic check_value(input string                     name,
                           input logic [`DIV_MSG_NBITS-1:0] expected,
                           input logic [`DIV_MSG_NBITS-1:0] actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("error: %s expected %h actual %h", name, expected, actual);
  end
endtask

// Present a request until it is accepted
// Returns the cycle number of the accepting rising edge
task automatic send_request(input  logic [`DIV_MSG_NBITS-1:0] msg,
                            output int                        accept_cycle);
  @(negedge clk);
  req_msg = msg;
  req_val = 1'b1;
  while (!req_rdy) begin
    @(negedge clk);
  end
  accept_cycle = cycle_count + 1;
  @(negedge clk);
  req_val = 1'b0;
  // Junk on the bus must not reach the busy datapath
  req_msg = {$urandom, $urandom};
endtask

// Wait for the response, check it, hold it back, then take it
task automatic take_response(input string                     name,
                             input logic [`DIV_MSG_NBITS-1:0] expected,
                             input int                        hold,
                             input int                        accept_cycle);
  logic [`DIV_MSG_NBITS-1:0] held_msg;
  int                        i;
  while (!resp_val) begin
    @(negedge clk);
  end
  check_value({name, " latency"}, `DIV_NBITS / 2, cycle_count - accept_cycle);
  check_value({name, " result"}, expected, resp_msg);
  held_msg = resp_msg;
  for (i = 0; i < hold; i++) begin
    @(negedge clk);
    check_value({name, " held resp_val"}, 1'b1, resp_val);
    check_value({name, " held resp_msg"}, held_msg, resp_msg);
    check_value({name, " req_rdy while held"}, 1'b0, req_rdy);
  end
  resp_rdy = 1'b1;
  @(negedge clk);
  resp_rdy = 1'b0;
  check_value({name, " req_rdy after response"}, 1'b1, req_rdy);
  check_value({name, " resp_val after response"}, 1'b0, resp_val);
endtask

`endif

// File: tb/intdiv_tb.sv
/*
 * Radix-4 divider testbench
 * Random and directed divides checked against a reference model
 */

`timescale 1ns/1ps
`default_nettype none

`include "intdiv_params.svh"

module intdiv_tb;

  // --------------------------------------------------------------------
  // Test sizes and run limit
  // --------------------------------------------------------------------

  localparam int num_random       = 200;
  localparam int num_edge         = 8;
  localparam int num_zero         = 4;
  localparam int num_latency      = 10;
  localparam int num_backpressure = 20;
  localparam int num_trans        = num_random + num_edge + num_zero +
                                    num_latency + num_backpressure;
  localparam int cycle_limit      = num_trans * (`DIV_NBITS / 2 + 12) + 100;

  localparam logic [`DIV_NBITS-1:0] max_operand = {`DIV_NBITS{1'b1}};

  logic                      clk;
  logic                      rst_n;
  logic [`DIV_MSG_NBITS-1:0] req_msg;
  logic                      req_val;
  logic                      req_rdy;
  logic [`DIV_MSG_NBITS-1:0] resp_msg;
  logic                      resp_val;
  logic                      resp_rdy;

  // Bookkeeping
  int cycle_count = 0;
  int check_count = 0;
  int error_count = 0;
  int test_count  = 0;
  int tests_failed = 0;
  int test_checks_start;
  int test_errors_start;

  intdiv dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  `include "intdiv_tb_tasks.svh"

  // --------------------------------------------------------------------
  // Clock and cycle limit
  // --------------------------------------------------------------------

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // --------------------------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------------------------

  // Quotient over remainder, all ones and the dividend on a zero divisor
  function automatic logic [`DIV_MSG_NBITS-1:0] model_divide(
    input logic [`DIV_NBITS-1:0] divisor,
    input logic [`DIV_NBITS-1:0] dividend
  );
    if (divisor == '0) begin
      return {max_operand, dividend};
    end
    return {dividend / divisor, dividend % divisor};
  endfunction

  // Random operand, narrowed to a few bits about a third of the time
  function automatic logic [`DIV_NBITS-1:0] random_operand();
    logic [`DIV_NBITS-1:0] value;
    int                    width;
    value = $urandom;
    if ($urandom_range(2, 0) == 0) begin
      width = $urandom_range(8, 1);
      value = value & (max_operand >> (`DIV_NBITS - width));
    end
    return value;
  endfunction

  task automatic start_test();
    test_checks_start = check_count;
    test_errors_start = error_count;
  endtask

  task automatic report_test(input string name);
    int errors;
    errors = error_count - test_errors_start;
    test_count++;
    if (errors != 0) begin
      tests_failed++;
    end
    $display("test %s done: %0d checks, %0d errors",
             name, check_count - test_checks_start, errors);
  endtask

  // One full transaction, optionally with resp_rdy raised ahead of time
  task automatic run_divide(input string                     name,
                            input logic [`DIV_NBITS-1:0]     divisor,
                            input logic [`DIV_NBITS-1:0]     dividend,
                            input logic [`DIV_MSG_NBITS-1:0] expected,
                            input int                        hold,
                            input logic                      early_ready);
    int accept_cycle;
    send_request({divisor, dividend}, accept_cycle);
    resp_rdy = early_ready;
    take_response(name, expected, hold, accept_cycle);
  endtask

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------

  initial begin
    logic [`DIV_NBITS-1:0] divisor;
    logic [`DIV_NBITS-1:0] dividend;
    int                    i;
    void'($urandom(32'h95bd_f2e5));
    rst_n    = 1'b0;
    req_msg  = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test();
    @(negedge clk);
    check_value("reset req_rdy", 1'b1, req_rdy);
    check_value("reset resp_val", 1'b0, resp_val);
    report_test("reset_state");

    start_test();
    for (i = 0; i < num_random; i++) begin
      divisor  = random_operand();
      dividend = $urandom;
      run_divide($sformatf("random %0d", i), divisor, dividend,
                 model_divide(divisor, dividend), 0, 1'b0);
    end
    report_test("random_divides");

    start_test();
    run_divide("small dividend", 100, 5, {{`DIV_NBITS{1'b0}}, 32'd5}, 0, 1'b0);
    run_divide("max divisor", max_operand, max_operand - 1,
               {{`DIV_NBITS{1'b0}}, max_operand - 1}, 0, 1'b0);
    run_divide("unit divisor", 1, 12345678, {32'd12345678, {`DIV_NBITS{1'b0}}}, 0, 1'b0);
    run_divide("unit divisor max", 1, max_operand,
               {max_operand, {`DIV_NBITS{1'b0}}}, 0, 1'b0);
    run_divide("max by max", max_operand, max_operand,
               model_divide(max_operand, max_operand), 0, 1'b0);
    run_divide("max by two", 2, max_operand, model_divide(2, max_operand), 0, 1'b0);
    divisor = {1'b1, {(`DIV_NBITS-1){1'b0}}};
    run_divide("max by top bit", divisor, max_operand,
               model_divide(divisor, max_operand), 0, 1'b0);
    run_divide("zero dividend", 3, 0, model_divide(3, 0), 0, 1'b0);
    report_test("edge_operands");

    start_test();
    run_divide("zero divisor 0", 0, 0, {max_operand, {`DIV_NBITS{1'b0}}}, 0, 1'b0);
    run_divide("zero divisor 1", 0, 1, {max_operand, 32'd1}, 0, 1'b0);
    run_divide("zero divisor max", 0, max_operand, {max_operand, max_operand}, 0, 1'b0);
    dividend = $urandom;
    run_divide("zero divisor random", 0, dividend, {max_operand, dividend}, 0, 1'b0);
    report_test("divide_by_zero");

    // Consumer ready before the result, so the latency is the only wait
    start_test();
    for (i = 0; i < num_latency; i++) begin
      divisor  = random_operand();
      dividend = $urandom;
      run_divide($sformatf("latency %0d", i), divisor, dividend,
                 model_divide(divisor, dividend), 0, 1'b1);
    end
    report_test("latency");

    start_test();
    for (i = 0; i < num_backpressure; i++) begin
      divisor  = random_operand();
      dividend = $urandom;
      run_divide($sformatf("backpressure %0d", i), divisor, dividend,
                 model_divide(divisor, dividend), $urandom_range(8, 1), 1'b0);
    end
    report_test("back_pressure");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/intdiv.sv
/*
 * Radix-4 unsigned integer divider
 * Valid/ready request of divisor and dividend, response of quotient and remainder
 */

`timescale 1ns/1ps
`default_nettype none

`include "intdiv_params.svh"

module intdiv (
  input  logic                      clk,
  input  logic                      rst_n,

  // Request: divisor in the upper half, dividend in the lower half
  input  logic [`DIV_MSG_NBITS-1:0] req_msg,
  input  logic                      req_val,
  output logic                      req_rdy,

  // Response: quotient in the upper half, remainder in the lower half
  output logic [`DIV_MSG_NBITS-1:0] resp_msg,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  // Controller strobes
  logic load;
  logic iterate;

  // --------------------------------------------------------------------
  // Controller
  // --------------------------------------------------------------------

  intdiv_ctrl ctrl0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .iterate  (iterate)
  );

  // --------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------

  intdiv_dpath dpath0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .iterate  (iterate),
    .req_msg  (req_msg),
    .resp_msg (resp_msg)
  );

endmodule

`default_nettype wire

// File: hw/intdiv_dpath.sv
/*
 * Radix-4 divider datapath
 * Remainder, divisor and quotient registers around one iteration step
 */

`timescale 1ns/1ps
`default_nettype none

`include "intdiv_params.svh"

module intdiv_dpath
  import intdiv_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      load,
  input  logic                      iterate,
  input  logic [`DIV_MSG_NBITS-1:0] req_msg,
  output logic [`DIV_MSG_NBITS-1:0] resp_msg
);

  // Working registers
  logic [`DIV_MSG_NBITS-1:0] remainder_q;
  logic [`DIV_MSG_NBITS-1:0] divisor_q;
  logic [`DIV_NBITS-1:0]     quotient_q;

  // Step results
  logic [`DIV_MSG_NBITS-1:0] step_remainder;
  logic [digit_nbits-1:0]    step_digit;

  // Operands as loaded from the request
  logic [`DIV_MSG_NBITS-1:0] load_remainder;
  logic [`DIV_MSG_NBITS-1:0] load_divisor;

  // --------------------------------------------------------------------
  // Operand unpacking
  // --------------------------------------------------------------------

  // Dividend zero-extended into the low half
  assign load_remainder = {{`DIV_NBITS{1'b0}}, req_msg[msg_hi_lsb-1:0]};

  // Divisor left-aligned one bit below the top, so the first trial
  // weighs quotient bit DIV_NBITS-1
  assign load_divisor = {1'b0, req_msg[`DIV_MSG_NBITS-1:msg_hi_lsb],
                         {(`DIV_NBITS-1){1'b0}}};

  // --------------------------------------------------------------------
  // Iteration step
  // --------------------------------------------------------------------

  intdiv_step step0 (
    .remainder      (remainder_q),
    .divisor        (divisor_q),
    .next_remainder (step_remainder),
    .digit          (step_digit)
  );

  // --------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remainder_q <= '0;
    end else if (load) begin
      remainder_q <= load_remainder;
    end else if (iterate) begin
      remainder_q <= step_remainder;
    end
  end

  // Two quotient bits consumed per step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      divisor_q <= '0;
    end else if (load) begin
      divisor_q <= load_divisor;
    end else if (iterate) begin
      divisor_q <= divisor_q >> digit_nbits;
    end
  end

  // New digit shifts in at the bottom
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quotient_q <= '0;
    end else if (load) begin
      quotient_q <= '0;
    end else if (iterate) begin
      quotient_q <= {quotient_q[`DIV_NBITS-digit_nbits-1:0], step_digit};
    end
  end

  // --------------------------------------------------------------------
  // Response packing
  // --------------------------------------------------------------------

  // Upper half of the remainder register is zero once iteration ends
  assign resp_msg[`DIV_MSG_NBITS-1:msg_hi_lsb] = quotient_q;
  assign resp_msg[msg_hi_lsb-1:0]              = remainder_q[msg_hi_lsb-1:0];

endmodule

`default_nettype wire

// File: hw/intdiv_ctrl.sv
/*
 * Radix-4 divider controller
 * Idle, calculate countdown and done states with the valid/ready outputs
 */

`timescale 1ns/1ps
`default_nettype none

`include "intdiv_params.svh"

module intdiv_ctrl
  import intdiv_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic iterate
);

  logic [`DIV_STATE_NBITS-1:0] state_q;
  logic [`DIV_STATE_NBITS-1:0] state_d;

  // State decode
  logic is_idle;
  logic is_done;
  logic is_calc;

  // Handshake transfers
  logic req_xfer;
  logic resp_xfer;

  assign is_idle = (state_q == state_idle);
  assign is_done = (state_q == state_done);
  assign is_calc = !is_idle && !is_done;

  assign req_xfer  = req_val && req_rdy;
  assign resp_xfer = resp_val && resp_rdy;

  // --------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    if (is_idle) begin
      if (req_xfer) begin
        state_d = state_calc;
      end
    end else if (is_done) begin
      if (resp_xfer) begin
        state_d = state_idle;
      end
    end else begin
      // Last calculate state is 2, which lands on done
      state_d = state_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= state_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------

  // Datapath keeps sampling the request while idle
  assign req_rdy = is_idle;
  assign load    = is_idle;

  assign iterate  = is_calc;
  assign resp_val = is_done;

endmodule

`default_nettype wire

// File: hw/intdiv_step.sv
/*
 * Radix-4 divider iteration
 * Two restoring trial subtractions give the next remainder and a quotient digit
 */

`timescale 1ns/1ps
`default_nettype none

`include "intdiv_params.svh"

module intdiv_step
  import intdiv_pkg::*;
(
  input  logic [`DIV_MSG_NBITS-1:0] remainder,
  input  logic [`DIV_MSG_NBITS-1:0] divisor,
  output logic [`DIV_MSG_NBITS-1:0] next_remainder,
  output logic [digit_nbits-1:0]    digit
);

  // First trial, against the full divisor
  logic [`DIV_MSG_NBITS-1:0] diff_full;
  logic                      neg_full;
  logic [`DIV_MSG_NBITS-1:0] mid_remainder;

  // Second trial, against half the divisor
  logic [`DIV_MSG_NBITS-1:0] half_divisor;
  logic [`DIV_MSG_NBITS-1:0] diff_half;
  logic                      neg_half;

  // --------------------------------------------------------------------
  // Upper quotient bit
  // --------------------------------------------------------------------

  // The divisor register keeps its top bit clear, so the MSB of the
  // difference is a reliable sign
  assign diff_full = remainder - divisor;
  assign neg_full  = diff_full[`DIV_MSG_NBITS-1];

  // Restore on a negative result
  always_comb begin
    if (neg_full) begin
      mid_remainder = remainder;
    end else begin
      mid_remainder = diff_full;
    end
  end

  // --------------------------------------------------------------------
  // Lower quotient bit
  // --------------------------------------------------------------------

  assign half_divisor = divisor >> 1;
  assign diff_half    = mid_remainder - half_divisor;
  assign neg_half     = diff_half[`DIV_MSG_NBITS-1];

  always_comb begin
    if (neg_half) begin
      next_remainder = mid_remainder;
    end else begin
      next_remainder = diff_half;
    end
  end

  // A trial that stays non-negative contributes a one
  assign digit = {~neg_full, ~neg_half};

endmodule

`default_nettype wire

// File: hw/intdiv_pkg.sv
/*
 * Radix-4 divider shared constants
 * Controller state codes and message field positions
 */

`default_nettype none

`include "intdiv_params.svh"

package intdiv_pkg;

  // --------------------------------------------------------------------
  // Controller countdown states
  // --------------------------------------------------------------------

  // Waiting for a request
  localparam logic [`DIV_STATE_NBITS-1:0] state_idle = `DIV_STATE_NBITS'(0);
  // Result held until the response is taken
  localparam logic [`DIV_STATE_NBITS-1:0] state_done = `DIV_STATE_NBITS'(1);
  // First iteration, the count runs down to 2
  localparam logic [`DIV_STATE_NBITS-1:0] state_calc =
    `DIV_STATE_NBITS'(`DIV_NBITS / 2 + 1);

  // --------------------------------------------------------------------
  // Message layout
  // --------------------------------------------------------------------

  // Upper field: divisor in a request, quotient in a response
  localparam int msg_hi_lsb  = `DIV_NBITS;
  // Quotient bits produced per iteration
  localparam int digit_nbits = 2;

endpackage

`default_nettype wire

// File: hw/intdiv_params.svh
/*
 * Radix-4 divider width parameters
 * Operand width and the widths derived from it
 */

`ifndef INTDIV_PARAMS_SVH
`define INTDIV_PARAMS_SVH

// Operand width in bits, must be even
`define DIV_NBITS 32

// Request and response words, also the internal remainder and divisor
`define DIV_MSG_NBITS (2 * `DIV_NBITS)

// Countdown state width
// Holds idle, done and DIV_NBITS/2 calculate states
`define DIV_STATE_NBITS ($clog2(`DIV_NBITS) + 1)

`endif
